// ==== hdl/ifetch_pkg.sv ====
// Shared definitions for the instruction fetch front end.
// Opcode encoding, line geometry and the instruction length rule,
// used by the RTL and by the testbench.
`default_nettype none

package ifetch_pkg;

   // Opcode sits in the top two bits of the first instruction byte
   typedef enum logic [1:0] {
      OP_NOP = 2'd0,
      OP_ALU = 2'd1,
      OP_IMM = 2'd2,
      OP_JMP = 2'd3
   } opcode_e;

   localparam int LINE_BYTES = 16;
   localparam int LINE_W     = LINE_BYTES * 8;

   // Valid byte count, 0 to 64
   localparam int CNT_W = 7;

   function automatic logic [3:0] insn_length(opcode_e op);
      case (op)
         OP_ALU:  return 4'd2;
         OP_IMM:  return 4'd5;
         OP_JMP:  return 4'd3;
         default: return 4'd1;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== hdl/byte_rotator.sv ====
// Byte rotator for the instruction window.
// Rotates two adjacent lines right by a byte count and returns the low line,
// so a window may start anywhere in the first line.
`timescale 1ns/1ps
`default_nettype none

module byte_rotator import ifetch_pkg::*; (
   input  logic [2*LINE_W-1:0] data_i,
   input  logic [3:0]          shift_i,
   output logic [LINE_W-1:0]   data_o
);

   always_comb begin
      logic [4:0] src;
      for (int b = 0; b < LINE_BYTES; b++) begin
         // Source byte index wraps within the 32 input bytes
         src = 5'(b) + 5'(shift_i);
         data_o[8*b +: 8] = data_i[8*src +: 8];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/line_fetcher.sv ====
// Line fetcher: reads 16-byte lines from instruction memory, one at a time,
// and holds the returned line until the queue takes it.
// A redirect restarts fetching and throws away a response still in flight.
`timescale 1ns/1ps
`default_nettype none

module line_fetcher import ifetch_pkg::*; #(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              redirect_i,
   input  logic [ADDR_W-1:0] redirect_addr_i,
   output logic              mem_req_o,
   output logic [ADDR_W-5:0] mem_addr_o,
   input  logic              mem_valid_i,
   input  logic [LINE_W-1:0] mem_data_i,
   output logic              line_valid_o,
   output logic [LINE_W-1:0] line_data_o,
   input  logic              line_ready_i
);

   logic [ADDR_W-5:0] next_line_q;
   logic              pending_q;
   logic              discard_q;
   logic              buf_valid_q;
   logic [LINE_W-1:0] buf_data_q;
   logic              issue;

   // Idle with an empty buffer, and not being redirected
   assign issue = !pending_q && !buf_valid_q && !redirect_i;

   assign line_valid_o = buf_valid_q;
   assign line_data_o  = buf_data_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         mem_req_o   <= 1'b0;
         pending_q   <= 1'b0;
         discard_q   <= 1'b0;
         buf_valid_q <= 1'b0;
         next_line_q <= '0;
      end else begin
         mem_req_o <= issue;
         if (redirect_i) begin
            next_line_q <= redirect_addr_i[ADDR_W-1:4];
            // A response arriving right now is stale as well
            pending_q   <= pending_q && !mem_valid_i;
            discard_q   <= pending_q && !mem_valid_i;
            buf_valid_q <= 1'b0;
         end else begin
            if (issue) begin
               pending_q   <= 1'b1;
               next_line_q <= next_line_q + 1'b1;
            end
            if (mem_valid_i && pending_q) begin
               pending_q <= 1'b0;
               discard_q <= 1'b0;
               if (!discard_q)
                  buf_valid_q <= 1'b1;
            end else if (buf_valid_q && line_ready_i) begin
               buf_valid_q <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue)
         mem_addr_o <= next_line_q;
      if (mem_valid_i && pending_q)
         buf_data_q <= mem_data_i;
   end

endmodule

`default_nettype wire

// ==== hdl/instruction_queue.sv ====
// Instruction queue: a ring of fetched lines with a byte-granular head.
// Presents the 16 bytes starting at the head together with the number of
// valid bytes, and advances by the count the decoder reports.
// A flush empties the ring and loads the head byte offset.
`timescale 1ns/1ps
`default_nettype none

module instruction_queue import ifetch_pkg::*; #(
   parameter int QDEPTH_LOG2 = 2
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              line_valid_i,
   input  logic [LINE_W-1:0] line_data_i,
   output logic              line_ready_o,
   input  logic              flush_i,
   input  logic [3:0]        load_offset_i,
   input  logic [3:0]        bytes_read_i,
   output logic [LINE_W-1:0] window_o,
   output logic [CNT_W-1:0]  valid_bytes_o
);

   localparam int DEPTH   = 2**QDEPTH_LOG2;
   localparam int HEAD_W  = QDEPTH_LOG2 + 4;
   localparam int FILL_W  = QDEPTH_LOG2 + 5;
   localparam int MAX_CNT = 2**CNT_W - 1;

   logic [LINE_W-1:0]      entry_q [DEPTH];
   logic [DEPTH-1:0]       entry_valid_q;
   logic [QDEPTH_LOG2-1:0] tail_q;
   logic [HEAD_W-1:0]      head_q;
   logic [HEAD_W-1:0]      head_next;
   logic [QDEPTH_LOG2-1:0] head_idx;
   logic [QDEPTH_LOG2-1:0] next_idx;
   logic                   in_accept;
   logic                   crossing;
   logic [QDEPTH_LOG2:0]   num_valid;
   logic [FILL_W-1:0]      fill_bytes;

   // Ready while any entry is free
   assign line_ready_o = ~&entry_valid_q;
   assign in_accept    = line_valid_i && line_ready_o;

   // Upper head bits pick the entry, low four bits the byte in it
   assign head_idx  = head_q[HEAD_W-1:4];
   assign next_idx  = head_idx + 1'b1;
   assign head_next = head_q + HEAD_W'(bytes_read_i);

   // Head leaves its entry, which is then free
   assign crossing = (bytes_read_i != 4'd0) && (head_next[HEAD_W-1:4] != head_idx);

   always_comb begin
      num_valid = '0;
      for (int i = 0; i < DEPTH; i++)
         num_valid = num_valid + entry_valid_q[i];
   end

   // Empty after a load with a nonzero offset must not go negative
   assign fill_bytes = (num_valid == '0) ? '0 :
                       {num_valid, 4'b0000} - FILL_W'(head_q[3:0]);

   assign valid_bytes_o = (int'(fill_bytes) > MAX_CNT) ? CNT_W'(MAX_CNT) :
                          CNT_W'(fill_bytes);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         tail_q        <= '0;
         head_q        <= '0;
         entry_valid_q <= '0;
      end else if (flush_i) begin
         tail_q        <= '0;
         head_q        <= HEAD_W'(load_offset_i);
         entry_valid_q <= '0;
      end else begin
         if (in_accept) begin
            tail_q                <= tail_q + 1'b1;
            entry_valid_q[tail_q] <= 1'b1;
         end
         if (crossing)
            entry_valid_q[head_idx] <= 1'b0;
         if (bytes_read_i != 4'd0)
            head_q <= head_next;
      end
   end

   always_ff @(posedge clk) begin
      if (in_accept)
         entry_q[tail_q] <= line_data_i;
   end

   // Head entry and its successor feed the rotator
   byte_rotator rot0 (
      .data_i  ({entry_q[next_idx], entry_q[head_idx]}),
      .shift_i (head_q[3:0]),
      .data_o  (window_o)
   );

endmodule

`default_nettype wire

// ==== hdl/length_decoder.sv ====
// Length decoder: takes one whole instruction per cycle off the window.
// Registers the instruction with its PC and length for the output port,
// and turns a JMP into a redirect of the fetcher and the queue.
`timescale 1ns/1ps
`default_nettype none

module length_decoder import ifetch_pkg::*; #(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic [LINE_W-1:0] window_i,
   input  logic [CNT_W-1:0]  valid_bytes_i,
   output logic [3:0]        bytes_read_o,
   output logic              redirect_o,
   output logic [ADDR_W-1:0] redirect_addr_o,
   output logic              insn_valid_o,
   input  logic              insn_ready_i,
   output logic [ADDR_W-1:0] insn_pc_o,
   output logic [3:0]        insn_len_o,
   output logic [LINE_W-1:0] insn_bytes_o
);

   opcode_e           op;
   logic [3:0]        len;
   logic [ADDR_W-1:0] pc_q;
   logic [ADDR_W-1:0] target;
   logic              out_free;
   logic              take;
   logic              is_jmp;

   assign op     = opcode_e'(window_i[7:6]);
   assign len    = insn_length(op);
   assign is_jmp = (op == OP_JMP);

   // Absolute target, low byte first
   assign target = ADDR_W'({window_i[23:16], window_i[15:8]});

   assign out_free = !insn_valid_o || insn_ready_i;

   // Empty window checked first, its first byte may not be known yet.
   // The cycle of a redirect still sees the old path, so nothing is taken
   assign take = (valid_bytes_i != '0) && (valid_bytes_i >= CNT_W'(len)) &&
                 out_free && !redirect_o;

   assign bytes_read_o = take ? len : 4'd0;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         insn_valid_o <= 1'b0;
         redirect_o   <= 1'b0;
         pc_q         <= '0;
      end else begin
         redirect_o <= take && is_jmp;
         if (take) begin
            insn_valid_o <= 1'b1;
            pc_q         <= is_jmp ? target : pc_q + ADDR_W'(len);
         end else if (insn_ready_i) begin
            insn_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         insn_pc_o       <= pc_q;
         insn_len_o      <= len;
         insn_bytes_o    <= window_i;
         redirect_addr_o <= target;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/ifetch_top.sv ====
// Top level of the instruction fetch front end.
// Connects the line fetcher, the instruction queue and the length decoder;
// a decoder redirect flushes the queue and restarts the fetcher.
`timescale 1ns/1ps
`default_nettype none

module ifetch_top import ifetch_pkg::*; #(
   parameter int ADDR_W      = 16,
   parameter int QDEPTH_LOG2 = 2
) (
   input  logic              clk,
   input  logic              rst_i,
   output logic              mem_req_o,
   output logic [ADDR_W-5:0] mem_addr_o,
   input  logic              mem_valid_i,
   input  logic [LINE_W-1:0] mem_data_i,
   output logic              insn_valid_o,
   input  logic              insn_ready_i,
   output logic [ADDR_W-1:0] insn_pc_o,
   output logic [3:0]        insn_len_o,
   output logic [LINE_W-1:0] insn_bytes_o
);

   logic              line_valid;
   logic [LINE_W-1:0] line_data;
   logic              line_ready;
   logic [LINE_W-1:0] window;
   logic [CNT_W-1:0]  valid_bytes;
   logic [3:0]        bytes_read;
   logic              redirect;
   logic [ADDR_W-1:0] redirect_addr;

   line_fetcher #(
      .ADDR_W (ADDR_W)
   ) fetch0 (
      .clk             (clk),
      .rst_i           (rst_i),
      .redirect_i      (redirect),
      .redirect_addr_i (redirect_addr),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .mem_valid_i     (mem_valid_i),
      .mem_data_i      (mem_data_i),
      .line_valid_o    (line_valid),
      .line_data_o     (line_data),
      .line_ready_i    (line_ready)
   );

   // Redirect is both the flush and the load of the queue
   instruction_queue #(
      .QDEPTH_LOG2 (QDEPTH_LOG2)
   ) queue0 (
      .clk           (clk),
      .rst_i         (rst_i),
      .line_valid_i  (line_valid),
      .line_data_i   (line_data),
      .line_ready_o  (line_ready),
      .flush_i       (redirect),
      .load_offset_i (redirect_addr[3:0]),
      .bytes_read_i  (bytes_read),
      .window_o      (window),
      .valid_bytes_o (valid_bytes)
   );

   length_decoder #(
      .ADDR_W (ADDR_W)
   ) decode0 (
      .clk             (clk),
      .rst_i           (rst_i),
      .window_i        (window),
      .valid_bytes_i   (valid_bytes),
      .bytes_read_o    (bytes_read),
      .redirect_o      (redirect),
      .redirect_addr_o (redirect_addr),
      .insn_valid_o    (insn_valid_o),
      .insn_ready_i    (insn_ready_i),
      .insn_pc_o       (insn_pc_o),
      .insn_len_o      (insn_len_o),
      .insn_bytes_o    (insn_bytes_o)
   );

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
// Clock and reset source for the testbench.
// Free-running clock and a synchronous reset held for a number of cycles.
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== sim/ifetch_checker.sv ====
// Protocol assertions for the fetch front end, bound to ifetch_top.
// Covers reset state, the single outstanding memory request and the held output.
`timescale 1ns/1ps
`default_nettype none

module ifetch_checker import ifetch_pkg::*; #(
   parameter int ADDR_W = 16
) (
   input logic              clk,
   input logic              rst_i,
   input logic              mem_req_i,
   input logic              mem_valid_i,
   input logic              insn_valid_i,
   input logic              insn_ready_i,
   input logic [ADDR_W-1:0] insn_pc_i,
   input logic [3:0]        insn_len_i,
   input logic [LINE_W-1:0] insn_bytes_i
);

   int   assert_errors = 0;
   logic outstanding;

   // Set by a request, cleared by the memory response
   always_ff @(posedge clk) begin
      if (rst_i)
         outstanding <= 1'b0;
      else if (mem_req_i)
         outstanding <= 1'b1;
      else if (mem_valid_i)
         outstanding <= 1'b0;
   end

   a_reset_quiet: assert property (@(posedge clk) rst_i |=> !mem_req_i && !insn_valid_i)
      else begin
         assert_errors++;
         $error("Request or instruction output active right after reset");
      end

   a_one_request: assert property (@(posedge clk) disable iff (rst_i)
      mem_req_i |-> !outstanding)
      else begin
         assert_errors++;
         $error("Second memory request issued while a response is pending");
      end

   a_hold_stable: assert property (@(posedge clk) disable iff (rst_i)
      insn_valid_i && !insn_ready_i |=> insn_valid_i && $stable(insn_pc_i) &&
      $stable(insn_len_i) && $stable(insn_bytes_i))
      else begin
         assert_errors++;
         $error("Held instruction output changed or dropped under back-pressure");
      end

endmodule

`default_nettype wire

// ==== sim/ifetch_monitor.sv ====
// Watches the memory port and the instruction port of the fetch front end.
// Compares each accepted instruction with the expected walk held in the testbench
// and prints one line per test, then the totals.
`timescale 1ns/1ps
`default_nettype none

module ifetch_monitor import ifetch_pkg::*; #(
   parameter int ADDR_W   = 16,
   parameter int NUM_INSN = 300
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              mem_req_i,
   input  logic [ADDR_W-5:0] mem_addr_i,
   input  logic              insn_valid_i,
   input  logic              insn_ready_i,
   input  logic [ADDR_W-1:0] insn_pc_i,
   input  logic [3:0]        insn_len_i,
   input  logic [LINE_W-1:0] insn_bytes_i,
   output logic              done_o,
   output int                errors_o
);

   int   accepted = 0;
   int   checks = 0;
   int   err_reset = 0;
   int   err_seq = 0;
   int   err_bytes = 0;
   int   err_jump = 0;
   int   err_bp = 0;
   int   n_jump = 0;
   int   n_held = 0;
   int   stall_cycles = 0;
   logic first_req_seen = 1'b0;
   logic held = 1'b0;

   initial done_o = 1'b0;

   assign errors_o = err_reset + err_seq + err_bytes + err_jump + err_bp;

   function automatic string verdict(int errs);
      return (errs == 0) ? "pass" : "fail";
   endfunction

   always @(posedge clk) begin : watch
      logic [ADDR_W-1:0] pc_exp;
      logic [7:0]        want;
      logic              bad;
      int                total;
      if (!rst_i && mem_req_i && !first_req_seen) begin
         first_req_seen = 1'b1;
         checks++;
         if (mem_addr_i != '0 || insn_valid_i) begin
            err_reset++;
            $display("Fail at %0t: first request for line %0d with insn_valid %b",
                     $time, mem_addr_i, insn_valid_i);
         end
         $display("Test reset and first request: %s", verdict(err_reset));
      end
      // A stalled instruction must come out unchanged later
      if (!rst_i && insn_valid_i && !insn_ready_i) begin
         held = 1'b1;
         stall_cycles++;
      end
      if (!rst_i && insn_valid_i && insn_ready_i && accepted < NUM_INSN) begin
         bad    = 1'b0;
         pc_exp = ifetch_tb.exp_pc[accepted];
         checks += 2;
         if (insn_pc_i != pc_exp || insn_len_i != ifetch_tb.exp_len[accepted]) begin
            bad = 1'b1;
            if (ifetch_tb.exp_after_jmp[accepted])
               err_jump++;
            else
               err_seq++;
            $display("Fail at %0t: insn %0d pc %h len %0d, expected pc %h len %0d",
                     $time, accepted, insn_pc_i, insn_len_i, pc_exp,
                     ifetch_tb.exp_len[accepted]);
         end
         for (int k = 0; k < ifetch_tb.exp_len[accepted]; k++) begin
            want = (k == 0) ? ifetch_tb.exp_first[accepted] : ifetch_tb.image[pc_exp + k];
            if (insn_bytes_i[8*k +: 8] != want && !bad) begin
               bad = 1'b1;
               err_bytes++;
               $display("Fail at %0t: insn %0d byte %0d is %h, expected %h",
                        $time, accepted, k, insn_bytes_i[8*k +: 8], want);
            end
         end
         if (ifetch_tb.exp_after_jmp[accepted])
            n_jump++;
         if (held) begin
            n_held++;
            if (bad)
               err_bp++;
            held = 1'b0;
         end
         accepted++;
         if (accepted == NUM_INSN) begin
            $display("Test sequential decode: %0d errors, %s", err_seq, verdict(err_seq));
            $display("Test instruction bytes: %0d errors, %s", err_bytes, verdict(err_bytes));
            $display("Test jumps: %0d targets, %0d errors, %s", n_jump, err_jump,
                     verdict(err_jump));
            if (stall_cycles == 0) begin
               err_bp++;
               $display("Back-pressure was never exercised, no stall cycles were seen");
            end
            $display("Test back-pressure: %0d stall cycles, %0d held, %s",
                     stall_cycles, n_held, verdict(err_bp));
            total = err_reset + err_seq + err_bytes + err_jump + err_bp;
            $display("Totals: %0d instructions, %0d checks, %0d errors",
                     accepted, checks, total);
            done_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/ifetch_tb.sv ====
// Testbench top for the instruction fetch front end.
// Builds a random program image, models the instruction memory with random
// latency, drives random back-pressure and decides the final result.
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb import ifetch_pkg::*; ();

   localparam int ADDR_W          = 16;
   localparam int QDEPTH_LOG2     = 2;
   localparam int NUM_INSN        = 300;
   localparam int IMAGE_BYTES     = 1024;
   localparam int RESET_CYCLES    = 5;
   localparam int CYCLES_PER_INSN = 40;

   logic              clk;
   logic              rst;
   logic              mem_req;
   logic [ADDR_W-5:0] mem_addr;
   logic              mem_valid = 1'b0;
   logic [LINE_W-1:0] mem_data = '0;
   logic              insn_valid;
   logic              insn_ready = 1'b0;
   logic [ADDR_W-1:0] insn_pc;
   logic [3:0]        insn_len;
   logic [LINE_W-1:0] insn_bytes;
   logic              mon_done;
   int                mon_errors;

   logic [7:0]        image [IMAGE_BYTES];
   int                exp_pc [NUM_INSN];
   int                exp_len [NUM_INSN];
   logic [7:0]        exp_first [NUM_INSN];
   logic              exp_after_jmp [NUM_INSN];
   int                seed = 32'h26693a76;
   int                lat_cnt = 0;
   logic [ADDR_W-5:0] req_line;

   // Length rule: NOP 1, ALU 2, IMM 5, JMP 3
   function automatic int ref_length(logic [7:0] first);
      case (opcode_e'(first[7:6]))
         OP_NOP:  return 1;
         OP_ALU:  return 2;
         OP_IMM:  return 5;
         default: return 3;
      endcase
   endfunction

   // Random bytes overlaid with an instruction stream whose jumps land on starts
   function automatic void build_image();
      int rnd;
      int pos;
      int tgt;
      int starts[$];
      int jumps[$];
      for (int i = 0; i < IMAGE_BYTES; i++) begin
         rnd = $random(seed);
         image[i] = rnd[7:0];
      end
      pos = 0;
      while (pos < IMAGE_BYTES - 8) begin
         rnd = $random(seed);
         image[pos][7:6] = rnd[1:0];
         starts.push_back(pos);
         if (opcode_e'(rnd[1:0]) == OP_JMP)
            jumps.push_back(pos);
         pos += ref_length(image[pos]);
      end
      starts.push_back(pos);
      jumps.push_back(pos);
      image[pos][7:6] = OP_JMP;
      foreach (jumps[j]) begin
         rnd = $random(seed);
         tgt = starts[(rnd & 32'h7fff_ffff) % starts.size()];
         image[jumps[j] + 1] = tgt[7:0];
         image[jumps[j] + 2] = tgt[15:8];
      end
   endfunction

   // Expected instruction sequence, starting at address 0
   function automatic void reference_walk();
      int   pc = 0;
      logic after = 1'b0;
      for (int n = 0; n < NUM_INSN; n++) begin
         exp_pc[n]        = pc;
         exp_first[n]     = image[pc];
         exp_len[n]       = ref_length(image[pc]);
         exp_after_jmp[n] = after;
         after            = (opcode_e'(image[pc][7:6]) == OP_JMP);
         pc = after ? {image[pc + 2], image[pc + 1]} : pc + exp_len[n];
      end
   endfunction

   function automatic logic [LINE_W-1:0] read_line(logic [ADDR_W-5:0] line);
      logic [LINE_W-1:0] d;
      for (int b = 0; b < LINE_BYTES; b++)
         d[8*b +: 8] = image[(int'(line) * LINE_BYTES + b) % IMAGE_BYTES];
      return d;
   endfunction

   initial begin
      build_image();
      reference_walk();
   end

   // Memory answers 1 to 4 cycles after a request, ready is high 3 cycles in 4
   always @(posedge clk) begin : memory_model
      int rnd;
      rnd = $random(seed);
      insn_ready <= (rnd[1:0] != 2'b00);
      mem_valid  <= 1'b0;
      if (rst) begin
         lat_cnt <= 0;
      end else begin
         if (lat_cnt == 1) begin
            mem_valid <= 1'b1;
            mem_data  <= read_line(req_line);
         end
         if (lat_cnt != 0)
            lat_cnt <= lat_cnt - 1;
         if (mem_req) begin
            req_line <= mem_addr;
            lat_cnt  <= 1 + rnd[3:2];
         end
      end
   end

   clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) clkgen0 (
      .clk_o (clk),
      .rst_o (rst)
   );

   ifetch_top #(.ADDR_W(ADDR_W), .QDEPTH_LOG2(QDEPTH_LOG2)) dut0 (
      .clk          (clk),
      .rst_i        (rst),
      .mem_req_o    (mem_req),
      .mem_addr_o   (mem_addr),
      .mem_valid_i  (mem_valid),
      .mem_data_i   (mem_data),
      .insn_valid_o (insn_valid),
      .insn_ready_i (insn_ready),
      .insn_pc_o    (insn_pc),
      .insn_len_o   (insn_len),
      .insn_bytes_o (insn_bytes)
   );

   ifetch_monitor #(.ADDR_W(ADDR_W), .NUM_INSN(NUM_INSN)) mon0 (
      .clk          (clk),
      .rst_i        (rst),
      .mem_req_i    (mem_req),
      .mem_addr_i   (mem_addr),
      .insn_valid_i (insn_valid),
      .insn_ready_i (insn_ready),
      .insn_pc_i    (insn_pc),
      .insn_len_i   (insn_len),
      .insn_bytes_i (insn_bytes),
      .done_o       (mon_done),
      .errors_o     (mon_errors)
   );

   bind ifetch_top ifetch_checker #(.ADDR_W(ADDR_W)) chk0 (
      .clk          (clk),
      .rst_i        (rst_i),
      .mem_req_i    (mem_req_o),
      .mem_valid_i  (mem_valid_i),
      .insn_valid_i (insn_valid_o),
      .insn_ready_i (insn_ready_i),
      .insn_pc_i    (insn_pc_o),
      .insn_len_i   (insn_len_o),
      .insn_bytes_i (insn_bytes_o)
   );

   initial begin : watchdog
      repeat (NUM_INSN * CYCLES_PER_INSN + RESET_CYCLES) @(posedge clk);
      $display("Timeout: fewer than %0d instructions were accepted in time", NUM_INSN);
      $display("TEST FAILED");
      $finish;
   end

   initial begin : finish_run
      wait (mon_done === 1'b1);
      @(posedge clk);
      if (dut0.chk0.assert_errors != 0)
         $display("%0d protocol assertions failed", dut0.chk0.assert_errors);
      if (mon_errors == 0 && dut0.chk0.assert_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/ifetch_pkg.sv
hdl/byte_rotator.sv
hdl/line_fetcher.sv
hdl/instruction_queue.sv
hdl/length_decoder.sv
hdl/ifetch_top.sv
sim/clk_gen.sv
sim/ifetch_checker.sv
sim/ifetch_monitor.sv
sim/ifetch_tb.sv

// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - files:
      - hdl/ifetch_pkg.sv
      - hdl/byte_rotator.sv
      - hdl/line_fetcher.sv
      - hdl/instruction_queue.sv
      - hdl/length_decoder.sv
      - hdl/ifetch_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/ifetch_checker.sv
      - sim/ifetch_monitor.sv
      - sim/ifetch_tb.sv
